//--- all.f
pong_pkg.sv
frame_timer.sv
paddle_motion.sv
ball_motion.sv
box_raster.sv
screen_painter.sv
pong_top.sv
tb_pong.sv

//--- run.sh
#!/bin/sh
# build and run the pong testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pong -f all.f

out=$(./obj_dir/Vtb_pong)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

//--- tb_pong.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pong import pong_pkg::*; ();

	localparam int SCREEN_X = 64;
	localparam int SCREEN_Y = 48;
	localparam int Y_MARGIN = 4;
	localparam int PADDLE_H = 10;
	localparam int PADDLE_W = 2;
	localparam int BALL_SIZE = 2;
	localparam int PADDLE_RATE = 3;
	localparam int BALL_RATE = 1;
	localparam int CLKS_PER_FRAME = 4000;
	localparam int CLK_PERIOD = 100;
	localparam int NUM_FRAMES = 300;
	localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * CLKS_PER_FRAME * CLK_PERIOD
		+ longint'(2) * CLKS_PER_FRAME * CLK_PERIOD;

	localparam int PAD_Y_MAX = SCREEN_Y - 1 - Y_MARGIN - PADDLE_H;
	localparam int BALL_X_LO = 2 + PADDLE_W;
	localparam int BALL_X_HI = SCREEN_X - PADDLE_W - BALL_SIZE;
	localparam int BALL_Y_MAX = SCREEN_Y - 1 - Y_MARGIN - BALL_SIZE;
	localparam int PADDLE_PIX = 2 * PADDLE_W * PADDLE_H;
	localparam int BALL_PIX = BALL_SIZE * BALL_SIZE;
	localparam int FRAME_PIX = 2 * PADDLE_PIX + 2 * BALL_PIX;
	localparam int SCREEN_PIX = SCREEN_X * SCREEN_Y;
	// cycle 1 is the first edge out of reset
	// the tick rises on edge CLKS_PER_FRAME and the positions move on the next edge
	localparam int FIRST_UPDATE = CLKS_PER_FRAME + 1;

	logic clk;
	logic resetn, enable;
	logic up1, down1, up2, down2;
	colour_t ball_colour;
	colour_t colour;
	logic [COORD_W-1:0] pix_x, pix_y;
	logic [COORD_W-1:0] ball_x, ball_y, paddle1_y, paddle2_y;
	logic plot, busy, lhs_scored, rhs_scored;

	// reference model state
	int m_p1, m_p2, m_bx, m_by;
	bit m_right, m_down, m_miss_l, m_miss_r;
	bit b_up1, b_down1, b_up2, b_down2;
	colour_t b_colour;

	int cyc, next_update, updates, score_frames, prev_bx, checks, paint_start;
	bit drive_pending, frame_scored, have_frame;
	int px_total, px_black, px_paddle, px_ball;
	int err [1:6];
	string test_name [1:6];

	always #(CLK_PERIOD / 2) clk = ~clk;

	pong_top #(
		.SCREEN_X(SCREEN_X),
		.SCREEN_Y(SCREEN_Y),
		.Y_MARGIN(Y_MARGIN),
		.BALL_SIZE(BALL_SIZE),
		.PADDLE_W(PADDLE_W),
		.PADDLE_H(PADDLE_H),
		.PADDLE_RATE(PADDLE_RATE),
		.BALL_RATE(BALL_RATE),
		.CLKS_PER_FRAME(CLKS_PER_FRAME)
	) uut (
		.clk(clk),
		.resetn(resetn),
		.enable(enable),
		.up1(up1),
		.down1(down1),
		.up2(up2),
		.down2(down2),
		.ball_colour(ball_colour),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.colour(colour),
		.plot(plot),
		.busy(busy),
		.lhs_scored(lhs_scored),
		.rhs_scored(rhs_scored),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.paddle1_y(paddle1_y),
		.paddle2_y(paddle2_y)
	);

	task automatic check_value(input int test, input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			err[test]++;
		end
	endtask

	task automatic expect_true(input int test, input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("at %0d ns: %s", $time, what);
			err[test]++;
		end
	endtask

	function automatic int step_paddle(input int y, input bit up, input bit down);
		if (up && !down) begin
			return (y - PADDLE_RATE < Y_MARGIN) ? Y_MARGIN : y - PADDLE_RATE;
		end else if (down && !up) begin
			return (y + PADDLE_RATE > PAD_Y_MAX) ? PAD_Y_MAX : y + PADDLE_RATE;
		end
		return y;
	endfunction

	function automatic bit overlaps(input int by, input int py);
		return (by + BALL_SIZE > py) && (py + PADDLE_H > by);
	endfunction

	// uses the paddle positions from before this frame's move
	task automatic step_ball();
		int nx;
		int ny;
		bit nd;
		nx = m_bx;
		ny = m_by;
		nd = m_down;
		m_miss_l = 1'b0;
		m_miss_r = 1'b0;
		if (m_down) begin
			if (m_by + BALL_RATE >= BALL_Y_MAX) begin
				ny = BALL_Y_MAX;
				nd = 1'b0;
			end else begin
				ny = m_by + BALL_RATE;
			end
		end else if (m_by <= Y_MARGIN + BALL_RATE) begin
			ny = Y_MARGIN;
			nd = 1'b1;
		end else begin
			ny = m_by - BALL_RATE;
		end
		if (m_right) begin
			if (m_bx < BALL_X_HI) begin
				nx = (m_bx + BALL_RATE >= BALL_X_HI) ? BALL_X_HI : m_bx + BALL_RATE;
			end else if (overlaps(m_by, m_p2)) begin
				nx = m_bx - BALL_RATE;
				m_right = 1'b0;
			end else begin
				m_miss_r = 1'b1;
			end
		end else begin
			if (m_bx > BALL_X_LO) begin
				nx = (m_bx <= BALL_X_LO + BALL_RATE) ? BALL_X_LO : m_bx - BALL_RATE;
			end else if (overlaps(m_by, m_p1)) begin
				nx = m_bx + BALL_RATE;
				m_right = 1'b1;
			end else begin
				m_miss_l = 1'b1;
			end
		end
		// serve again from the centre, directions kept
		if (m_miss_l || m_miss_r) begin
			nx = (SCREEN_X - BALL_SIZE) / 2;
			ny = (SCREEN_Y - BALL_SIZE) / 2;
		end
		m_bx = nx;
		m_by = ny;
		m_down = nd;
	endtask

	// a score frame blanks the whole screen in place of the three erases
	task automatic check_frame();
		int t;
		t = frame_scored ? 5 : 4;
		check_value(t, "plotted pixels", px_total,
			frame_scored ? SCREEN_PIX + PADDLE_PIX + BALL_PIX : FRAME_PIX);
		check_value(t, "black pixels", px_black,
			frame_scored ? SCREEN_PIX : PADDLE_PIX + BALL_PIX);
		check_value(t, "paddle pixels", px_paddle, PADDLE_PIX);
		check_value(t, "ball pixels", px_ball, BALL_PIX);
	endtask

	task automatic tally_pixel();
		int t;
		t = frame_scored ? 5 : 4;
		px_total++;
		expect_true(t, pix_x < SCREEN_X && pix_y < SCREEN_Y,
			$sformatf("pixel (%0d,%0d) was plotted outside the screen", pix_x, pix_y));
		if (colour == COL_BLACK) begin
			px_black++;
		end else if (colour == COL_PADDLE) begin
			px_paddle++;
			expect_true(t, (pix_x >= 2 && pix_x < 2 + PADDLE_W) || pix_x >= SCREEN_X - PADDLE_W,
				"a paddle pixel was plotted outside the paddle columns");
		end else if (colour == b_colour) begin
			px_ball++;
			expect_true(t, pix_x >= m_bx && pix_x < m_bx + BALL_SIZE
				&& pix_y >= m_by && pix_y < m_by + BALL_SIZE,
				"a ball pixel was plotted outside the ball box");
		end else begin
			expect_true(t, 1'b0, $sformatf("a pixel was plotted in unknown colour %0d", colour));
		end
	endtask

	task automatic drive_inputs();
		b_up1 = 1'($urandom_range(0, 1));
		b_down1 = 1'($urandom_range(0, 1));
		b_up2 = 1'($urandom_range(0, 1));
		b_down2 = 1'($urandom_range(0, 1));
		b_colour = colour_t'($urandom_range(1, 6));
		up1 <= b_up1;
		down1 <= b_down1;
		up2 <= b_up2;
		down2 <= b_down2;
		ball_colour <= b_colour;
	endtask

	task automatic sample_cycle();
		bit is_update;
		is_update = (cyc == next_update);
		if (cyc == next_update - 1) begin
			check_value(6, "busy at frame tick", busy, 0);
		end
		if (cyc == paint_start) begin
			check_value(6, "busy after update", busy, 1);
		end
		if (!busy) begin
			expect_true(6, !plot, "plot is high while busy is low");
		end
		check_value(1, "ball_x moved", ball_x != prev_bx, is_update);
		if (is_update) begin
			if (have_frame) begin
				check_frame();
			end
			px_total = 0;
			px_black = 0;
			px_paddle = 0;
			px_ball = 0;
			step_ball();
			m_p1 = step_paddle(m_p1, b_up1, b_down1);
			m_p2 = step_paddle(m_p2, b_up2, b_down2);
			check_value(2, "paddle1_y", paddle1_y, m_p1);
			check_value(2, "paddle2_y", paddle2_y, m_p2);
			check_value(3, "ball_x", ball_x, m_bx);
			check_value(3, "ball_y", ball_y, m_by);
			frame_scored = m_miss_l || m_miss_r;
			if (frame_scored) begin
				score_frames++;
			end
			have_frame = 1'b1;
			updates++;
			// the painter leaves idle on the edge after the update
			paint_start = cyc + 1;
			next_update += CLKS_PER_FRAME;
			drive_pending = 1'b1;
		end
		check_value(3, "lhs_scored", lhs_scored, is_update && m_miss_r);
		check_value(3, "rhs_scored", rhs_scored, is_update && m_miss_l);
		if (plot) begin
			tally_pixel();
		end
		prev_bx = ball_x;
	endtask

	initial begin
		int failed;
		int total;
		void'($urandom(32'hb05c8a82));
		test_name[1] = "frame tick timing";
		test_name[2] = "paddle motion";
		test_name[3] = "ball motion and scoring";
		test_name[4] = "normal frame painting";
		test_name[5] = "score frame painting";
		test_name[6] = "busy and plot";
		for (int i = 1; i <= 6; i++) begin
			err[i] = 0;
		end
		clk = 1'b0;
		resetn = 1'b0;
		enable = 1'b1;
		up1 = 1'b0;
		down1 = 1'b0;
		up2 = 1'b0;
		down2 = 1'b0;
		ball_colour = 3'd1;
		b_colour = 3'd1;
		m_p1 = (SCREEN_Y - PADDLE_H) / 2;
		m_p2 = (SCREEN_Y - PADDLE_H) / 2;
		m_bx = (SCREEN_X - BALL_SIZE) / 2;
		m_by = (SCREEN_Y - BALL_SIZE) / 2;
		m_right = 1'b1;
		m_down = 1'b1;
		cyc = 0;
		next_update = FIRST_UPDATE;
		paint_start = 0;
		updates = 0;
		score_frames = 0;
		checks = 0;
		have_frame = 1'b0;
		frame_scored = 1'b0;

		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		prev_bx = ball_x;
		drive_pending = 1'b1;

		// one pass per clock, runs on until the last frame is painted
		while (updates < NUM_FRAMES || busy || cyc < paint_start) begin
			@(posedge clk);
			if (drive_pending) begin
				drive_inputs();
				drive_pending = 1'b0;
			end
			cyc++;
			@(negedge clk);
			sample_cycle();
		end
		check_frame();
		expect_true(5, score_frames > 0, "no frame with a score came up in the run");

		failed = 0;
		total = 0;
		for (int i = 1; i <= 6; i++) begin
			$display("test %0d, %s: %0d errors, %s", i, test_name[i], err[i],
				(err[i] == 0) ? "ok" : "failed");
			total += err[i];
			if (err[i] != 0) begin
				failed++;
			end
		end
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d score frames",
			6, failed, checks, total, score_frames);
		if (failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- pong_top.sv
`timescale 1ns/1ps
`default_nettype none

module pong_top import pong_pkg::*; #(
	parameter int SCREEN_X = 320,
	parameter int SCREEN_Y = 240,
	parameter int Y_MARGIN = 20,
	parameter int BALL_SIZE = 4,
	parameter int PADDLE_W = 5,
	parameter int PADDLE_H = 40,
	parameter int PADDLE_RATE = 3,
	parameter int BALL_RATE = 1,
	parameter int CLKS_PER_FRAME = 833333
) (
	input wire clk,
	input wire resetn,
	input wire enable,
	input wire up1,
	input wire down1,
	input wire up2,
	input wire down2,
	input wire colour_t ball_colour,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	output colour_t colour,
	output logic plot,
	output logic busy,
	output logic lhs_scored,
	output logic rhs_scored,
	output logic [COORD_W-1:0] ball_x,
	output logic [COORD_W-1:0] ball_y,
	output logic [COORD_W-1:0] paddle1_y,
	output logic [COORD_W-1:0] paddle2_y
);

	logic frame_tick;
	logic [COORD_W-1:0] old_paddle1_y, old_paddle2_y;
	logic [COORD_W-1:0] old_ball_x, old_ball_y;

	frame_timer #(
		.CLKS_PER_FRAME(CLKS_PER_FRAME)
	) u_timer (
		.clk(clk),
		.resetn(resetn),
		.enable(enable),
		.frame_tick(frame_tick)
	);

	paddle_motion #(
		.SCREEN_Y(SCREEN_Y),
		.Y_MARGIN(Y_MARGIN),
		.PADDLE_H(PADDLE_H),
		.PADDLE_RATE(PADDLE_RATE)
	) u_paddles (
		.clk(clk),
		.resetn(resetn),
		.frame_tick(frame_tick),
		.up1(up1),
		.down1(down1),
		.up2(up2),
		.down2(down2),
		.paddle1_y(paddle1_y),
		.paddle2_y(paddle2_y),
		.old_paddle1_y(old_paddle1_y),
		.old_paddle2_y(old_paddle2_y)
	);

	ball_motion #(
		.SCREEN_X(SCREEN_X),
		.SCREEN_Y(SCREEN_Y),
		.Y_MARGIN(Y_MARGIN),
		.BALL_SIZE(BALL_SIZE),
		.PADDLE_W(PADDLE_W),
		.PADDLE_H(PADDLE_H),
		.BALL_RATE(BALL_RATE)
	) u_ball (
		.clk(clk),
		.resetn(resetn),
		.frame_tick(frame_tick),
		.paddle1_y(paddle1_y),
		.paddle2_y(paddle2_y),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.old_ball_x(old_ball_x),
		.old_ball_y(old_ball_y),
		.lhs_scored(lhs_scored),
		.rhs_scored(rhs_scored)
	);

	screen_painter #(
		.SCREEN_X(SCREEN_X),
		.SCREEN_Y(SCREEN_Y),
		.BALL_SIZE(BALL_SIZE),
		.PADDLE_W(PADDLE_W),
		.PADDLE_H(PADDLE_H)
	) u_painter (
		.clk(clk),
		.resetn(resetn),
		.frame_tick(frame_tick),
		.lhs_scored(lhs_scored),
		.rhs_scored(rhs_scored),
		.ball_colour(ball_colour),
		.paddle1_y(paddle1_y),
		.paddle2_y(paddle2_y),
		.old_paddle1_y(old_paddle1_y),
		.old_paddle2_y(old_paddle2_y),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.old_ball_x(old_ball_x),
		.old_ball_y(old_ball_y),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.colour(colour),
		.plot(plot),
		.busy(busy)
	);

endmodule

`default_nettype wire

//--- screen_painter.sv
`timescale 1ns/1ps
`default_nettype none

module screen_painter import pong_pkg::*; #(
	parameter int SCREEN_X = 320,
	parameter int SCREEN_Y = 240,
	parameter int BALL_SIZE = 4,
	parameter int PADDLE_W = 5,
	parameter int PADDLE_H = 40
) (
	input wire clk,
	input wire resetn,
	input wire frame_tick,
	input wire lhs_scored,
	input wire rhs_scored,
	input wire colour_t ball_colour,
	input wire [COORD_W-1:0] paddle1_y,
	input wire [COORD_W-1:0] paddle2_y,
	input wire [COORD_W-1:0] old_paddle1_y,
	input wire [COORD_W-1:0] old_paddle2_y,
	input wire [COORD_W-1:0] ball_x,
	input wire [COORD_W-1:0] ball_y,
	input wire [COORD_W-1:0] old_ball_x,
	input wire [COORD_W-1:0] old_ball_y,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	output colour_t colour,
	output logic plot,
	output logic busy
);

	localparam logic [COORD_W-1:0] P1_X = COORD_W'(2);
	localparam logic [COORD_W-1:0] P2_X = COORD_W'(SCREEN_X - PADDLE_W);
	localparam logic [COORD_W-1:0] PAD_W_C = COORD_W'(PADDLE_W);
	localparam logic [COORD_W-1:0] PAD_H_C = COORD_W'(PADDLE_H);
	localparam logic [COORD_W-1:0] BALL_C = COORD_W'(BALL_SIZE);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_BLANK = 3'd1;
	localparam logic [2:0] S_ERASE1 = 3'd2;
	localparam logic [2:0] S_DRAW1 = 3'd3;
	localparam logic [2:0] S_ERASE2 = 3'd4;
	localparam logic [2:0] S_DRAW2 = 3'd5;
	localparam logic [2:0] S_ERASEB = 3'd6;
	localparam logic [2:0] S_DRAWB = 3'd7;

	logic [2:0] state, next_step;
	logic tick_d;
	logic launch;
	logic blank;
	logic scored;
	logic box_done;
	logic [COORD_W-1:0] org_x, org_y, size_x, size_y;

	assign scored = lhs_scored || rhs_scored;
	assign busy = (state != S_IDLE);

	// step that follows the current box, erases skipped after a blank
	always_comb begin
		case (state)
			S_BLANK: next_step = S_DRAW1;
			S_ERASE1: next_step = S_DRAW1;
			S_DRAW1: next_step = blank ? S_DRAW2 : S_ERASE2;
			S_ERASE2: next_step = S_DRAW2;
			S_DRAW2: next_step = blank ? S_DRAWB : S_ERASEB;
			S_ERASEB: next_step = S_DRAWB;
			default: next_step = S_IDLE;
		endcase
	end

	// origin, size and colour of the box for each step
	always_comb begin
		org_x = '0;
		org_y = '0;
		size_x = PAD_W_C;
		size_y = PAD_H_C;
		colour = COL_BLACK;
		case (state)
			S_BLANK: begin
				size_x = COORD_W'(SCREEN_X);
				size_y = COORD_W'(SCREEN_Y);
			end
			S_ERASE1: begin
				org_x = P1_X;
				org_y = old_paddle1_y;
			end
			S_DRAW1: begin
				org_x = P1_X;
				org_y = paddle1_y;
				colour = COL_PADDLE;
			end
			S_ERASE2: begin
				org_x = P2_X;
				org_y = old_paddle2_y;
			end
			S_DRAW2: begin
				org_x = P2_X;
				org_y = paddle2_y;
				colour = COL_PADDLE;
			end
			S_ERASEB: begin
				org_x = old_ball_x;
				org_y = old_ball_y;
				size_x = BALL_C;
				size_y = BALL_C;
			end
			S_DRAWB: begin
				org_x = ball_x;
				org_y = ball_y;
				size_x = BALL_C;
				size_y = BALL_C;
				colour = ball_colour;
			end
			default: ;
		endcase
	end

	// positions and score pulses are valid one cycle after the tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_IDLE;
			tick_d <= 1'b0;
			launch <= 1'b0;
			blank <= 1'b0;
		end else begin
			tick_d <= frame_tick;
			launch <= 1'b0;
			if (state == S_IDLE) begin
				if (tick_d) begin
					blank <= scored;
					state <= scored ? S_BLANK : S_ERASE1;
					launch <= 1'b1;
				end
			end else if (box_done) begin
				state <= next_step;
				launch <= (next_step != S_IDLE);
			end
		end
	end

	box_raster u_raster (
		.clk(clk),
		.resetn(resetn),
		.start(launch),
		.org_x(org_x),
		.org_y(org_y),
		.size_x(size_x),
		.size_y(size_y),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.plot(plot),
		.done(box_done)
	);

	// frame too short for the drawing sequence
	a_frame_overrun: assert property (@(posedge clk) disable iff (!resetn)
		frame_tick |-> !busy);

endmodule

`default_nettype wire

//--- box_raster.sv
`timescale 1ns/1ps
`default_nettype none

module box_raster import pong_pkg::*; (
	input wire clk,
	input wire resetn,
	input wire start,
	input wire [COORD_W-1:0] org_x,
	input wire [COORD_W-1:0] org_y,
	input wire [COORD_W-1:0] size_x,
	input wire [COORD_W-1:0] size_y,
	output logic [COORD_W-1:0] pix_x,
	output logic [COORD_W-1:0] pix_y,
	output logic plot,
	output logic done
);

	logic [COORD_W-1:0] base_x, base_y;
	logic [COORD_W-1:0] last_x, last_y;
	logic [COORD_W-1:0] cnt_x, cnt_y;
	logic row_end;

	assign row_end = (cnt_x == last_x);
	assign done = plot && row_end && (cnt_y == last_y);
	assign pix_x = base_x + cnt_x;
	assign pix_y = base_y + cnt_y;

	// box geometry captured at start
	always_ff @(posedge clk) begin
		if (start) begin
			base_x <= org_x;
			base_y <= org_y;
			last_x <= size_x - 1'b1;
			last_y <= size_y - 1'b1;
		end
	end

	// columns inside rows, one pixel per clock
	always_ff @(posedge clk) begin
		if (!resetn) begin
			plot <= 1'b0;
			cnt_x <= '0;
			cnt_y <= '0;
		end else if (start) begin
			plot <= 1'b1;
			cnt_x <= '0;
			cnt_y <= '0;
		end else if (plot) begin
			if (done) begin
				plot <= 1'b0;
			end else if (row_end) begin
				cnt_x <= '0;
				cnt_y <= cnt_y + 1'b1;
			end else begin
				cnt_x <= cnt_x + 1'b1;
			end
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
		start |-> !plot);

endmodule

`default_nettype wire

//--- ball_motion.sv
`timescale 1ns/1ps
`default_nettype none

module ball_motion import pong_pkg::*; #(
	parameter int SCREEN_X = 320,
	parameter int SCREEN_Y = 240,
	parameter int Y_MARGIN = 20,
	parameter int BALL_SIZE = 4,
	parameter int PADDLE_W = 5,
	parameter int PADDLE_H = 40,
	parameter int BALL_RATE = 1
) (
	input wire clk,
	input wire resetn,
	input wire frame_tick,
	input wire [COORD_W-1:0] paddle1_y,
	input wire [COORD_W-1:0] paddle2_y,
	output logic [COORD_W-1:0] ball_x,
	output logic [COORD_W-1:0] ball_y,
	output logic [COORD_W-1:0] old_ball_x,
	output logic [COORD_W-1:0] old_ball_y,
	output logic lhs_scored,
	output logic rhs_scored
);

	localparam logic [COORD_W-1:0] X_LO = COORD_W'(2 + PADDLE_W);
	localparam logic [COORD_W-1:0] X_HI = COORD_W'(SCREEN_X - PADDLE_W - BALL_SIZE);
	localparam logic [COORD_W-1:0] Y_LO = COORD_W'(Y_MARGIN);
	localparam logic [COORD_W-1:0] Y_HI = COORD_W'(SCREEN_Y - 1 - Y_MARGIN - BALL_SIZE);
	localparam logic [COORD_W-1:0] X_CTR = COORD_W'((SCREEN_X - BALL_SIZE) / 2);
	localparam logic [COORD_W-1:0] Y_CTR = COORD_W'((SCREEN_Y - BALL_SIZE) / 2);
	localparam logic [COORD_W-1:0] STEP = COORD_W'(BALL_RATE);
	localparam logic [COORD_W-1:0] BALL_C = COORD_W'(BALL_SIZE);
	localparam logic [COORD_W-1:0] PAD_H_C = COORD_W'(PADDLE_H);

	logic x_right;
	logic y_down;
	logic hit1, hit2;
	logic [COORD_W-1:0] nx, ny;
	logic nx_right, ny_down;
	logic miss_l, miss_r;

	// vertical spans of ball and paddle overlap
	assign hit1 = (ball_y + BALL_C > paddle1_y) && (paddle1_y + PAD_H_C > ball_y);
	assign hit2 = (ball_y + BALL_C > paddle2_y) && (paddle2_y + PAD_H_C > ball_y);

	always_comb begin
		nx = ball_x;
		ny = ball_y;
		nx_right = x_right;
		ny_down = y_down;
		miss_l = 1'b0;
		miss_r = 1'b0;

		// a margin reached or crossed clamps and turns the ball
		if (y_down) begin
			if (ball_y + STEP >= Y_HI) begin
				ny = Y_HI;
				ny_down = 1'b0;
			end else begin
				ny = ball_y + STEP;
			end
		end else begin
			if (ball_y <= Y_LO + STEP) begin
				ny = Y_LO;
				ny_down = 1'b1;
			end else begin
				ny = ball_y - STEP;
			end
		end

		if (x_right) begin
			if (ball_x >= X_HI) begin
				if (hit2) begin
					nx_right = 1'b0;
					nx = ball_x - STEP;
				end else begin
					miss_r = 1'b1;
				end
			end else begin
				nx = (ball_x + STEP >= X_HI) ? X_HI : ball_x + STEP;
			end
		end else begin
			if (ball_x <= X_LO) begin
				if (hit1) begin
					nx_right = 1'b1;
					nx = ball_x + STEP;
				end else begin
					miss_l = 1'b1;
				end
			end else begin
				nx = (ball_x <= X_LO + STEP) ? X_LO : ball_x - STEP;
			end
		end

		// a miss serves again from the centre, directions kept
		if (miss_l || miss_r) begin
			nx = X_CTR;
			ny = Y_CTR;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_right <= 1'b1;
			y_down <= 1'b1;
			ball_x <= X_CTR;
			ball_y <= Y_CTR;
			old_ball_x <= X_CTR;
			old_ball_y <= Y_CTR;
			lhs_scored <= 1'b0;
			rhs_scored <= 1'b0;
		end else begin
			lhs_scored <= frame_tick && miss_r;
			rhs_scored <= frame_tick && miss_l;
			if (frame_tick) begin
				old_ball_x <= ball_x;
				old_ball_y <= ball_y;
				ball_x <= nx;
				ball_y <= ny;
				x_right <= nx_right;
				y_down <= ny_down;
			end
		end
	end

	a_one_side: assert property (@(posedge clk) disable iff (!resetn)
		!(lhs_scored && rhs_scored));

	// score is a single-cycle pulse
	a_score_pulse: assert property (@(posedge clk) disable iff (!resetn)
		(lhs_scored || rhs_scored) |=> !(lhs_scored || rhs_scored));

endmodule

`default_nettype wire

//--- paddle_motion.sv
`timescale 1ns/1ps
`default_nettype none

module paddle_motion import pong_pkg::*; #(
	parameter int SCREEN_Y = 240,
	parameter int Y_MARGIN = 20,
	parameter int PADDLE_H = 40,
	parameter int PADDLE_RATE = 3
) (
	input wire clk,
	input wire resetn,
	input wire frame_tick,
	input wire up1,
	input wire down1,
	input wire up2,
	input wire down2,
	output logic [COORD_W-1:0] paddle1_y,
	output logic [COORD_W-1:0] paddle2_y,
	output logic [COORD_W-1:0] old_paddle1_y,
	output logic [COORD_W-1:0] old_paddle2_y
);

	localparam logic [COORD_W-1:0] Y_MIN = COORD_W'(Y_MARGIN);
	localparam logic [COORD_W-1:0] Y_MAX = COORD_W'(SCREEN_Y - 1 - Y_MARGIN - PADDLE_H);
	localparam logic [COORD_W-1:0] Y_CTR = COORD_W'((SCREEN_Y - PADDLE_H) / 2);
	localparam logic [COORD_W-1:0] STEP = COORD_W'(PADDLE_RATE);

	dir_t dir1;
	dir_t dir2;

	// both or neither pressed means hold
	function automatic dir_t decode_dir(input logic up, input logic down);
		case ({up, down})
			2'b10: return DIR_UP;
			2'b01: return DIR_DOWN;
			default: return DIR_HOLD;
		endcase
	endfunction

	function automatic logic [COORD_W-1:0] step_y(input logic [COORD_W-1:0] y, input dir_t dir);
		logic [COORD_W-1:0] ny;
		ny = y;
		if (dir == DIR_UP) begin
			ny = (y < Y_MIN + STEP) ? Y_MIN : y - STEP;
		end else if (dir == DIR_DOWN) begin
			ny = (y + STEP > Y_MAX) ? Y_MAX : y + STEP;
		end
		return ny;
	endfunction

	assign dir1 = decode_dir(up1, down1);
	assign dir2 = decode_dir(up2, down2);

	// buttons sampled on the tick edge
	always_ff @(posedge clk) begin
		if (!resetn) begin
			paddle1_y <= Y_CTR;
			paddle2_y <= Y_CTR;
			old_paddle1_y <= Y_CTR;
			old_paddle2_y <= Y_CTR;
		end else begin
			if (frame_tick) begin
				old_paddle1_y <= paddle1_y;
				old_paddle2_y <= paddle2_y;
				paddle1_y <= step_y(paddle1_y, dir1);
				paddle2_y <= step_y(paddle2_y, dir2);
			end
		end
	end

	a_clamp: assert property (@(posedge clk) disable iff (!resetn)
		paddle1_y >= Y_MIN && paddle1_y <= Y_MAX && paddle2_y >= Y_MIN && paddle2_y <= Y_MAX);

endmodule

`default_nettype wire

//--- frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
	parameter int CLKS_PER_FRAME = 833333
) (
	input wire clk,
	input wire resetn,
	input wire enable,
	output logic frame_tick
);

	localparam int CNT_W = (CLKS_PER_FRAME > 1) ? $clog2(CLKS_PER_FRAME) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_FRAME - 1);

	logic [CNT_W-1:0] count;

	// counts down while enabled, the reload cycle carries the tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= RELOAD;
			frame_tick <= 1'b0;
		end else begin
			frame_tick <= 1'b0;
			if (enable) begin
				if (count == '0) begin
					count <= RELOAD;
					frame_tick <= 1'b1;
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- pong_pkg.sv
`default_nettype none

package pong_pkg;

	// width of every screen coordinate and box size
	localparam int COORD_W = 10;

	// 3-bit rgb pixel colour
	typedef logic [2:0] colour_t;

	localparam colour_t COL_BLACK = 3'b000;
	localparam colour_t COL_PADDLE = 3'b111;

	// paddle command decoded from a button pair
	typedef logic [1:0] dir_t;

	localparam dir_t DIR_HOLD = 2'd0;
	localparam dir_t DIR_UP = 2'd1;
	localparam dir_t DIR_DOWN = 2'd2;

endpackage

`default_nettype wire
